//--- Bender.yml
package:
  name: soc_mem_side

sources:
  - soc_pkg.sv
  - soc_addr_decoder.sv
  - soc_l2_mem.sv
  - soc_ctrl_regs.sv
  - soc_apb_bridge.sv
  - soc_top.sv
  - target: test
    files:
      - soc_asserts.sv
      - tb_soc.sv

//--- soc_addr_decoder.sv
// Address decoder for the single bus master port
// Picks the target region, raises its request and forms the grant.
// The granted region is registered to steer the response one cycle later.

`timescale 1ns/100ps
`default_nettype none

module soc_addr_decoder import soc_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 req_i,
  input  wire logic [AddrWidth-1:0] addr_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output logic                      err_o,
  output logic                      l2_req_o,
  output logic                      ctrl_req_o,
  output logic                      uart_req_o,
  input  wire logic                 uart_done_i,
  input  wire logic                 uart_err_i,
  input  wire logic [DataWidth-1:0] l2_rdata_i,
  input  wire logic [DataWidth-1:0] ctrl_rdata_i,
  input  wire logic [DataWidth-1:0] uart_rdata_i,
  output logic [DataWidth-1:0]      rdata_o
);

  region_e region;
  region_e region_q;
  logic    rvalid_q;

  // Offset compare wraps, so one check covers both bounds
  always_comb begin
    region = RegionNone;
    if ((addr_i - DramBase) < DramLength) begin
      region = RegionL2;
    end else if ((addr_i - UartBase) < UartLength) begin
      region = RegionUart;
    end else if ((addr_i - CtrlBase) < CtrlLength) begin
      region = RegionCtrl;
    end
  end

  assign l2_req_o   = req_i && (region == RegionL2);
  assign ctrl_req_o = req_i && (region == RegionCtrl);
  assign uart_req_o = req_i && (region == RegionUart);

  // UART waits for the bridge, everything else is granted at once
  assign gnt_o = req_i && ((region == RegionUart) ? uart_done_i : 1'b1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      region_q <= RegionNone;
    end else begin
      rvalid_q <= gnt_o;
      if (gnt_o) begin
        region_q <= region;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (region_q)
      RegionL2:   rdata_o = l2_rdata_i;
      RegionCtrl: rdata_o = ctrl_rdata_i;
      RegionUart: rdata_o = uart_rdata_i;
      default:    rdata_o = '0;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q && ((region_q == RegionNone) ||
                                 ((region_q == RegionUart) && uart_err_i));

endmodule

`default_nettype wire

//--- soc_apb_bridge.sv
// APB master bridge to the UART
// Turns one 64-bit bus request into a 32-bit APB transfer and
// keeps the last response for the decoder

`timescale 1ns/100ps
`default_nettype none

module soc_apb_bridge import soc_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic                    req_i,
  input  wire logic                    we_i,
  input  wire logic [AddrWidth-1:0]    addr_i,
  input  wire logic [DataWidth-1:0]    wdata_i,
  input  wire logic [StrbWidth-1:0]    be_i,
  output logic                         done_o,
  output logic [DataWidth-1:0]         rdata_o,
  output logic                         err_o,
  output logic                         psel_o,
  output logic                         penable_o,
  output logic                         pwrite_o,
  output logic [AddrWidth-1:0]         paddr_o,
  output logic [ApbDataWidth-1:0]      pwdata_o,
  input  wire logic [ApbDataWidth-1:0] prdata_i,
  input  wire logic                    pready_i,
  input  wire logic                    pslverr_i
);

  typedef enum logic [1:0] {
    Idle,
    Setup,
    Access
  } state_e;

  state_e                  state_q, state_d;
  logic                    we_q;
  logic [AddrWidth-1:0]    addr_q;
  logic [ApbDataWidth-1:0] wdata_q;
  logic [ApbDataWidth-1:0] lane_wdata;
  logic [DataWidth-1:0]    rdata_q;
  logic                    err_q;

  // Lane by address bit 2; APB3 has no pstrb, disabled bytes go out as zero
  always_comb begin
    lane_wdata = addr_i[2] ? wdata_i[DataWidth-1 -: ApbDataWidth] : wdata_i[ApbDataWidth-1:0];
    for (int b = 0; b < ApbDataWidth/8; b++) begin
      if (!be_i[addr_i[2]*(ApbDataWidth/8) + b]) begin
        lane_wdata[b*8 +: 8] = 8'h00;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:    if (req_i) state_d = Setup;
      Setup:   state_d = Access;
      Access:  if (pready_i) state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (done_o) begin
        err_q <= pslverr_i;
      end
    end
  end

  // Request payload and read data
  always_ff @(posedge clk_i) begin
    if (state_q == Idle && req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= lane_wdata;
    end
    if (done_o) begin
      rdata_q <= addr_q[2] ? {prdata_i, {ApbDataWidth{1'b0}}} : {{ApbDataWidth{1'b0}}, prdata_i};
    end
  end

  assign done_o    = (state_q == Access) && pready_i;
  assign psel_o    = (state_q != Idle);
  assign penable_o = (state_q == Access);
  assign pwrite_o  = we_q;
  assign paddr_o   = addr_q;
  assign pwdata_o  = wdata_q;
  assign rdata_o   = rdata_q;
  assign err_o     = err_q;

endmodule

`default_nettype wire

//--- soc_asserts.sv
// Protocol checks for the APB bridge and the response path
// Bound into the bridge and into the address decoder

`timescale 1ns/100ps
`default_nettype none

module soc_asserts import soc_pkg::*; (
  input wire logic                    clk_i,
  input wire logic                    rst_n_i,
  input wire logic                    psel_i,
  input wire logic                    penable_i,
  input wire logic                    pready_i,
  input wire logic                    pwrite_i,
  input wire logic [AddrWidth-1:0]    paddr_i,
  input wire logic [ApbDataWidth-1:0] pwdata_i,
  input wire logic                    gnt_i,
  input wire logic                    rvalid_i
);

  int unsigned fail_count = 0;

  // Setup always moves on to access
  setup_then_enable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    psel_i && !penable_i |=> psel_i && penable_i)
    else begin
      fail_count++;
      $error("APB setup cycle not followed by an access cycle");
    end

  stable_while_waiting: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    psel_i && penable_i && !pready_i |=>
      $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i))
    else begin
      fail_count++;
      $error("APB address or data changed while waiting for pready");
    end

  rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> $past(gnt_i))
    else begin
      fail_count++;
      $error("Response valid without a grant in the previous cycle");
    end

endmodule

bind soc_apb_bridge soc_asserts i_apb_asserts (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .psel_i   (psel_o),
  .penable_i(penable_o),
  .pready_i (pready_i),
  .pwrite_i (pwrite_o),
  .paddr_i  (paddr_o),
  .pwdata_i (pwdata_o),
  .gnt_i    (1'b0),
  .rvalid_i (1'b0)
);

bind soc_addr_decoder soc_asserts i_rsp_asserts (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .psel_i   (1'b0),
  .penable_i(1'b0),
  .pready_i (1'b0),
  .pwrite_i (1'b0),
  .paddr_i  ('0),
  .pwdata_i ('0),
  .gnt_i    (gnt_o),
  .rvalid_i (rvalid_o)
);

`default_nettype wire

//--- soc_ctrl_regs.sv
// Control and status registers
// Exit, counter enable and event trigger are writable levels,
// the DRAM bounds read back as constants

`timescale 1ns/100ps
`default_nettype none

module soc_ctrl_regs import soc_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 req_i,
  input  wire logic                 we_i,
  input  wire logic [AddrWidth-1:0] addr_i,
  input  wire logic [DataWidth-1:0] wdata_i,
  input  wire logic [StrbWidth-1:0] be_i,
  output logic [DataWidth-1:0]      rdata_o,
  output logic [DataWidth-1:0]      exit_o,
  output logic [DataWidth-1:0]      hw_cnt_en_o,
  output logic [DataWidth-1:0]      event_trigger_o
);

  logic [CtrlOffWidth-1:0] offset;
  logic [DataWidth-1:0]    exit_q;
  logic [DataWidth-1:0]    cnt_en_q;
  logic [DataWidth-1:0]    event_q;
  logic [DataWidth-1:0]    rdata_d;
  logic [DataWidth-1:0]    rdata_q;

  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_val,
                                                       input logic [DataWidth-1:0] new_val,
                                                       input logic [StrbWidth-1:0] be);
    logic [DataWidth-1:0] res;
    res = old_val;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign offset = addr_i[CtrlOffWidth-1:0];

  always_comb begin
    case (offset)
      CtrlExitOffset:     rdata_d = exit_q;
      CtrlCntEnOffset:    rdata_d = cnt_en_q;
      CtrlEventOffset:    rdata_d = event_q;
      CtrlDramBaseOffset: rdata_d = {{(DataWidth-AddrWidth){1'b0}}, DramBase};
      CtrlDramEndOffset:  rdata_d = {{(DataWidth-AddrWidth){1'b0}}, DramBase + DramLength};
      default:            rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      event_q  <= '0;
      rdata_q  <= '0;
    end else if (req_i) begin
      if (we_i) begin
        if (offset == CtrlExitOffset)  exit_q   <= merge_bytes(exit_q, wdata_i, be_i);
        if (offset == CtrlCntEnOffset) cnt_en_q <= merge_bytes(cnt_en_q, wdata_i, be_i);
        if (offset == CtrlEventOffset) event_q  <= merge_bytes(event_q, wdata_i, be_i);
      end else begin
        rdata_q <= rdata_d;
      end
    end
  end

  assign rdata_o         = rdata_q;
  assign exit_o          = exit_q;
  assign hw_cnt_en_o     = cnt_en_q;
  assign event_trigger_o = event_q;

endmodule

`default_nettype wire

//--- soc_l2_mem.sv
// Main memory
// Byte-enabled single-port array with one cycle of read latency

`timescale 1ns/100ps
`default_nettype none

module soc_l2_mem import soc_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 req_i,
  input  wire logic                 we_i,
  input  wire logic [AddrWidth-1:0] addr_i,
  input  wire logic [DataWidth-1:0] wdata_i,
  input  wire logic [StrbWidth-1:0] be_i,
  output logic [DataWidth-1:0]      rdata_o
);

  logic [DataWidth-1:0]  mem_q [L2NumWords];
  logic [DataWidth-1:0]  rdata_q;
  logic [L2IdxWidth-1:0] idx;

  // Upper address bits drop out of the word index so the region wraps
  assign idx = addr_i[ByteOffset +: L2IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- soc_pkg.sv
// SoC memory-side package
// Bus widths, region map, control register offsets and region encoding

`default_nettype none

package soc_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ByteOffset   = $clog2(StrbWidth);
  localparam int unsigned ApbDataWidth = 32;

  // Main memory depth in 64-bit words
  localparam int unsigned L2NumWords = 1024;
  localparam int unsigned L2IdxWidth = $clog2(L2NumWords);

  ////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////

  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] UartBase   = 32'hC000_0000;
  localparam logic [AddrWidth-1:0] UartLength = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] CtrlBase   = 32'hD000_0000;
  localparam logic [AddrWidth-1:0] CtrlLength = 32'h0000_1000;

  // Control register byte offsets
  localparam int unsigned CtrlOffWidth = $clog2(CtrlLength);
  localparam logic [CtrlOffWidth-1:0] CtrlExitOffset     = 'h00;
  localparam logic [CtrlOffWidth-1:0] CtrlCntEnOffset    = 'h08;
  localparam logic [CtrlOffWidth-1:0] CtrlEventOffset    = 'h10;
  localparam logic [CtrlOffWidth-1:0] CtrlDramBaseOffset = 'h18;
  localparam logic [CtrlOffWidth-1:0] CtrlDramEndOffset  = 'h20;

  typedef enum logic [1:0] {
    RegionL2   = 2'd0,
    RegionUart = 2'd1,
    RegionCtrl = 2'd2,
    RegionNone = 2'd3
  } region_e;

endpackage

`default_nettype wire

//--- soc_top.sv
// SoC memory side
// Bus master port decoded onto main memory, control registers
// and the UART behind an APB bridge

`timescale 1ns/100ps
`default_nettype none

module soc_top import soc_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  // Master port
  input  wire logic                    req_i,
  input  wire logic                    we_i,
  input  wire logic [AddrWidth-1:0]    addr_i,
  input  wire logic [DataWidth-1:0]    wdata_i,
  input  wire logic [StrbWidth-1:0]    be_i,
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output logic [DataWidth-1:0]         rdata_o,
  output logic                         err_o,
  // UART APB port
  output logic                         uart_psel_o,
  output logic                         uart_penable_o,
  output logic                         uart_pwrite_o,
  output logic [AddrWidth-1:0]         uart_paddr_o,
  output logic [ApbDataWidth-1:0]      uart_pwdata_o,
  input  wire logic [ApbDataWidth-1:0] uart_prdata_i,
  input  wire logic                    uart_pready_i,
  input  wire logic                    uart_pslverr_i,
  // Register levels
  output logic [DataWidth-1:0]         exit_o,
  output logic [DataWidth-1:0]         hw_cnt_en_o,
  output logic [DataWidth-1:0]         event_trigger_o
);

  logic                 l2_req;
  logic                 ctrl_req;
  logic                 uart_req;
  logic                 uart_done;
  logic                 uart_err;
  logic [DataWidth-1:0] l2_rdata;
  logic [DataWidth-1:0] ctrl_rdata;
  logic [DataWidth-1:0] uart_rdata;

  soc_addr_decoder i_decoder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .addr_i      (addr_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .err_o       (err_o),
    .l2_req_o    (l2_req),
    .ctrl_req_o  (ctrl_req),
    .uart_req_o  (uart_req),
    .uart_done_i (uart_done),
    .uart_err_i  (uart_err),
    .l2_rdata_i  (l2_rdata),
    .ctrl_rdata_i(ctrl_rdata),
    .uart_rdata_i(uart_rdata),
    .rdata_o     (rdata_o)
  );

  soc_l2_mem i_l2_mem (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (l2_req),
    .we_i   (we_i),
    .addr_i (addr_i),
    .wdata_i(wdata_i),
    .be_i   (be_i),
    .rdata_o(l2_rdata)
  );

  soc_ctrl_regs i_ctrl_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (ctrl_req),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .rdata_o        (ctrl_rdata),
    .exit_o         (exit_o),
    .hw_cnt_en_o    (hw_cnt_en_o),
    .event_trigger_o(event_trigger_o)
  );

  soc_apb_bridge i_apb_bridge (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (uart_req),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .be_i     (be_i),
    .done_o   (uart_done),
    .rdata_o  (uart_rdata),
    .err_o    (uart_err),
    .psel_o   (uart_psel_o),
    .penable_o(uart_penable_o),
    .pwrite_o (uart_pwrite_o),
    .paddr_o  (uart_paddr_o),
    .pwdata_o (uart_pwdata_o),
    .prdata_i (uart_prdata_i),
    .pready_i (uart_pready_i),
    .pslverr_i(uart_pslverr_i)
  );

endmodule

`default_nettype wire

//--- tb_soc.sv
// Testbench for the SoC memory side
// Directed tests over main memory, control registers, the UART
// behind the APB bridge and unmapped space

`timescale 1ns/100ps
`default_nettype none

module tb_soc import soc_pkg::*; ();

  localparam int ClkPeriod      = 20;
  localparam int NumMemAddrs    = 12;
  localparam int NumAccesses    = 4 * NumMemAddrs + 22;
  localparam int WatchdogCycles = NumAccesses * 8 + 50;
  localparam int GrantLimit     = 16;
  localparam logic [11:0] UartErrOffset = 12'h040;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    req_i;
  logic                    we_i;
  logic [AddrWidth-1:0]    addr_i;
  logic [DataWidth-1:0]    wdata_i;
  logic [StrbWidth-1:0]    be_i;
  logic                    gnt_o;
  logic                    rvalid_o;
  logic [DataWidth-1:0]    rdata_o;
  logic                    err_o;
  logic                    uart_psel_o;
  logic                    uart_penable_o;
  logic                    uart_pwrite_o;
  logic [AddrWidth-1:0]    uart_paddr_o;
  logic [ApbDataWidth-1:0] uart_pwdata_o;
  logic [ApbDataWidth-1:0] uart_prdata_i;
  logic                    uart_pready_i;
  logic                    uart_pslverr_i;
  logic [DataWidth-1:0]    exit_o;
  logic [DataWidth-1:0]    hw_cnt_en_o;
  logic [DataWidth-1:0]    event_trigger_o;

  int          errors;
  int          checks;
  int          assert_fails;
  int          grant_wait;
  int          apb_waits;
  int          wait_left;
  int          psel_cycles;
  logic [31:0] lfsr;
  logic [63:0] wait_bits;
  logic [63:0] rsp_rdata;
  logic        rsp_err;
  logic [31:0] apb_paddr;
  logic [31:0] apb_pwdata;
  logic        apb_pwrite;
  logic [63:0] exp_exit;
  logic [63:0] exp_cnt_en;
  logic [63:0] exp_event;
  logic [63:0] mem_model [L2NumWords];
  logic [31:0] mem_addrs [NumMemAddrs];
  logic [31:0] uart_regs [1024];
  logic [63:0] uart_wdata [2];

  soc_top uut (.*);

  initial clk_i = 1'b0;
  always #(ClkPeriod/2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[62:0], lfsr[0]};
    end
  endtask

  function automatic logic [63:0] apply_be(input logic [63:0] old_val,
                                           input logic [63:0] new_val,
                                           input logic [7:0] be);
    logic [63:0] res;
    for (int b = 0; b < 8; b++) begin
      res[b*8 +: 8] = be[b] ? new_val[b*8 +: 8] : old_val[b*8 +: 8];
    end
    return res;
  endfunction

  // Word slot inside the DRAM region modulo the depth
  function automatic int mem_index(input logic [31:0] addr);
    return ((addr - DramBase) >> 3) % L2NumWords;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR at %0t ns: %s", $time, what);
    end
  endtask

  // One request, held until granted, then the response one cycle later
  task automatic bus_access(input logic write, input logic [31:0] addr,
                            input logic [63:0] wdata, input logic [7:0] be);
    @(posedge clk_i);
    #2;
    req_i      = 1'b1;
    we_i       = write;
    addr_i     = addr;
    wdata_i    = wdata;
    be_i       = be;
    grant_wait = 0;
    forever begin
      @(negedge clk_i);
      check_value("rvalid_o", rvalid_o, 1'b0);
      if (gnt_o || grant_wait == GrantLimit) break;
      grant_wait++;
    end
    check_true(gnt_o, $sformatf("request to %h got no grant", addr));
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    we_i  = 1'b0;
    @(negedge clk_i);
    check_true(rvalid_o, $sformatf("no response one cycle after grant to %h", addr));
    rsp_rdata = rdata_o;
    rsp_err   = err_o;
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [63:0] exp,
                             input logic exp_err, input int exp_wait);
    bus_access(1'b0, addr, '0, '0);
    if (!exp_err) begin
      check_value("rdata_o", rsp_rdata, exp);
    end
    check_value("err_o", rsp_err, exp_err);
    check_value("grant wait", grant_wait, exp_wait);
  endtask

  // Grant wait follows the wait states the APB slave drew for this access
  task automatic uart_read_expect(input logic [31:0] addr, input logic [63:0] exp,
                                  input logic exp_err);
    bus_access(1'b0, addr, '0, '0);
    if (!exp_err) begin
      check_value("rdata_o", rsp_rdata, exp);
    end
    check_value("err_o", rsp_err, exp_err);
    check_value("uart_pwrite_o", apb_pwrite, 1'b0);
    check_value("uart_paddr_o", apb_paddr, addr);
    check_value("grant wait", grant_wait, 2 + apb_waits);
  endtask

  task automatic write_ctrl_reg(input logic [11:0] offset, input logic [63:0] data,
                                input logic [7:0] be, inout logic [63:0] shadow);
    shadow = apply_be(shadow, data, be);
    bus_access(1'b1, CtrlBase + offset, data, be);
    check_value("err_o", rsp_err, 1'b0);
    check_value("grant wait", grant_wait, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // APB slave model
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    #2;
    if (uart_psel_o && !uart_penable_o) begin
      draw_bits(2, wait_bits);
      apb_waits     = int'(wait_bits);
      wait_left     = apb_waits;
      uart_pready_i = 1'b0;
    end else if (uart_psel_o && uart_penable_o && !uart_pready_i) begin
      if (wait_left == 0) begin
        apb_paddr  = uart_paddr_o;
        apb_pwrite = uart_pwrite_o;
        apb_pwdata = uart_pwdata_o;
        if (uart_pwrite_o) begin
          uart_regs[uart_paddr_o[11:2]] = uart_pwdata_o;
        end else begin
          uart_prdata_i = uart_regs[uart_paddr_o[11:2]];
        end
        uart_pslverr_i = (uart_paddr_o[11:0] == UartErrOffset);
        uart_pready_i  = 1'b1;
      end else begin
        wait_left--;
      end
    end else begin
      uart_pready_i  = 1'b0;
      uart_pslverr_i = 1'b0;
    end
  end

  always @(negedge clk_i) begin
    if (uart_psel_o) psel_cycles++;
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    @(negedge clk_i);
    check_value("gnt_o", gnt_o, 1'b0);
    check_value("rvalid_o", rvalid_o, 1'b0);
    check_value("err_o", err_o, 1'b0);
    check_value("uart_psel_o", uart_psel_o, 1'b0);
    check_value("uart_penable_o", uart_penable_o, 1'b0);
    check_value("exit_o", exit_o, '0);
    check_value("hw_cnt_en_o", hw_cnt_en_o, '0);
    check_value("event_trigger_o", event_trigger_o, '0);
  endtask

  task automatic read_burst();
    @(posedge clk_i);
    for (int i = 0; i <= NumMemAddrs; i++) begin
      #2;
      req_i = (i < NumMemAddrs);
      we_i  = 1'b0;
      if (i < NumMemAddrs) addr_i = mem_addrs[i];
      @(negedge clk_i);
      if (i < NumMemAddrs) check_value("gnt_o", gnt_o, 1'b1);
      check_value("rvalid_o", rvalid_o, i > 0);
      if (i > 0) begin
        check_value("rdata_o", rdata_o, mem_model[mem_index(mem_addrs[i-1])]);
        check_value("err_o", err_o, 1'b0);
      end
      @(posedge clk_i);
    end
  endtask

  task automatic test_memory();
    logic [63:0] bits;
    logic [63:0] data;
    logic [63:0] be_bits;
    int          idx;
    // Base, an alias one depth above, the region top, then random offsets
    mem_addrs[0] = DramBase;
    mem_addrs[1] = DramBase + L2NumWords * 8;
    mem_addrs[2] = DramBase + DramLength - 8;
    for (int i = 3; i < NumMemAddrs; i++) begin
      draw_bits(30, bits);
      mem_addrs[i] = DramBase + {bits[29:3], 3'b000};
    end
    // First pass writes whole words, second pass merges random bytes
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < NumMemAddrs; i++) begin
        draw_bits(64, data);
        draw_bits(8, be_bits);
        if (pass == 0) be_bits = 64'hFF;
        idx = mem_index(mem_addrs[i]);
        mem_model[idx] = apply_be(mem_model[idx], data, be_bits[7:0]);
        bus_access(1'b1, mem_addrs[i], data, be_bits[7:0]);
        check_value("err_o", rsp_err, 1'b0);
        check_value("grant wait", grant_wait, 0);
      end
    end
    for (int i = 0; i < NumMemAddrs; i++) begin
      read_expect(mem_addrs[i], mem_model[mem_index(mem_addrs[i])], 1'b0, 0);
    end
    read_burst();
  endtask

  task automatic test_ctrl_regs();
    logic [63:0] data;
    draw_bits(64, data);
    write_ctrl_reg(CtrlExitOffset, data, 8'hFF, exp_exit);
    draw_bits(64, data);
    write_ctrl_reg(CtrlCntEnOffset, data, 8'h0F, exp_cnt_en);
    draw_bits(64, data);
    write_ctrl_reg(CtrlCntEnOffset, data, 8'hF0, exp_cnt_en);
    draw_bits(64, data);
    write_ctrl_reg(CtrlEventOffset, data, 8'h3C, exp_event);
    check_value("exit_o", exit_o, exp_exit);
    check_value("hw_cnt_en_o", hw_cnt_en_o, exp_cnt_en);
    check_value("event_trigger_o", event_trigger_o, exp_event);
    read_expect(CtrlBase + CtrlExitOffset, exp_exit, 1'b0, 0);
    read_expect(CtrlBase + CtrlCntEnOffset, exp_cnt_en, 1'b0, 0);
    read_expect(CtrlBase + CtrlEventOffset, exp_event, 1'b0, 0);
    read_expect(CtrlBase + CtrlDramBaseOffset, 64'h0000_0000_8000_0000, 1'b0, 0);
    read_expect(CtrlBase + CtrlDramEndOffset, 64'h0000_0000_C000_0000, 1'b0, 0);
    read_expect(CtrlBase + 32'h28, '0, 1'b0, 0);
    read_expect(CtrlBase + 32'hFF8, '0, 1'b0, 0);
  endtask

  task automatic test_uart_writes();
    logic [63:0] data;
    for (int i = 0; i < 2; i++) begin
      draw_bits(64, data);
      uart_wdata[i] = data;
      bus_access(1'b1, UartBase + 32'h10 + 4 * i, data, 8'hFF);
      check_value("uart_paddr_o", apb_paddr, UartBase + 32'h10 + 4 * i);
      check_value("uart_pwrite_o", apb_pwrite, 1'b1);
      check_value("uart_pwdata_o", apb_pwdata, (i == 1) ? data[63:32] : data[31:0]);
      check_value("grant wait", grant_wait, 2 + apb_waits);
      check_value("err_o", rsp_err, 1'b0);
    end
  endtask

  task automatic test_uart_reads();
    uart_read_expect(UartBase + 32'h10, {32'h0, uart_wdata[0][31:0]}, 1'b0);
    uart_read_expect(UartBase + 32'h14, {uart_wdata[1][63:32], 32'h0}, 1'b0);
    // Untouched register still holds its fill value
    uart_read_expect(UartBase + 32'h24, {32'h5A00_0024, 32'h0}, 1'b0);
    uart_read_expect(UartBase + UartErrOffset, '0, 1'b1);
    uart_read_expect(UartBase + 32'h10, {32'h0, uart_wdata[0][31:0]}, 1'b0);
  endtask

  task automatic test_unmapped();
    int psel_before;
    psel_before = psel_cycles;
    bus_access(1'b1, 32'h0000_1000, 64'hDEAD_BEEF_0BAD_F00D, 8'hFF);
    check_value("err_o", rsp_err, 1'b1);
    check_value("grant wait", grant_wait, 0);
    bus_access(1'b1, CtrlBase + CtrlLength, 64'h1234_5678_9ABC_DEF0, 8'hFF);
    check_value("err_o", rsp_err, 1'b1);
    read_expect(UartBase + UartLength, '0, 1'b1, 0);
    read_expect(32'hE000_0000, '0, 1'b1, 0);
    check_value("psel cycles", psel_cycles - psel_before, 0);
    check_value("exit_o", exit_o, exp_exit);
    check_value("hw_cnt_en_o", hw_cnt_en_o, exp_cnt_en);
    check_value("event_trigger_o", event_trigger_o, exp_event);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    lfsr           = 32'h096bbb57;
    errors         = 0;
    checks         = 0;
    psel_cycles    = 0;
    wait_left      = 0;
    apb_waits      = 0;
    exp_exit       = '0;
    exp_cnt_en     = '0;
    exp_event      = '0;
    rst_n_i        = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    wdata_i        = '0;
    be_i           = '0;
    uart_prdata_i  = '0;
    uart_pready_i  = 1'b0;
    uart_pslverr_i = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      uart_regs[i] = 32'h5A00_0000 | (i << 2);
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    test_reset_values();
    test_memory();
    test_ctrl_regs();
    test_uart_writes();
    test_uart_reads();
    test_unmapped();
    assert_fails = uut.i_apb_bridge.i_apb_asserts.fail_count +
                   uut.i_decoder.i_rsp_asserts.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, tests did not finish", WatchdogCycles);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
soc_pkg.sv
soc_addr_decoder.sv
soc_l2_mem.sv
soc_ctrl_regs.sv
soc_apb_bridge.sv
soc_top.sv
soc_asserts.sv
tb_soc.sv
